//--- source/bus_cfg_pkg.sv
// cluster bus configuration
`default_nettype none

package bus_cfg_pkg;

  // bus geometry
  localparam int unsigned ADDR_WIDTH    = 32;
  localparam int unsigned DATA_WIDTH    = 32;
  localparam int unsigned NB_INITIATORS = 4;
  localparam int unsigned NB_TARGETS    = 3;

  // cluster address map, cluster n sits at CLUSTER_BASE + (n << CLUSTER_SHIFT)
  localparam logic [ADDR_WIDTH-1:0] CLUSTER_BASE  = 32'h1000_0000;
  localparam int unsigned           CLUSTER_SHIFT = 22;
  localparam logic [ADDR_WIDTH-1:0] PERIPH_OFFSET = 32'h0020_0000;
  localparam logic [ADDR_WIDTH-1:0] CLUSTER_SPAN  = 32'h0040_0000;

  typedef logic [1:0] tgt_idx_t;
  typedef logic [1:0] ini_idx_t;

  // target port numbering
  localparam tgt_idx_t TGT_TCDM   = 2'd0;
  localparam tgt_idx_t TGT_PERIPH = 2'd1;
  localparam tgt_idx_t TGT_EXT    = 2'd2;

  // all upper bounds are exclusive
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] tcdm_start;
    logic [ADDR_WIDTH-1:0] tcdm_end;
    logic [ADDR_WIDTH-1:0] periph_start;
    logic [ADDR_WIDTH-1:0] periph_end;
    logic [ADDR_WIDTH-1:0] cluster_start;
    logic [ADDR_WIDTH-1:0] cluster_end;
  } addr_rules_t;

endpackage

`default_nettype wire

//--- source/bus_txn_pkg.sv
// cluster bus transaction types
`default_nettype none

package bus_txn_pkg;

  // single-beat request from an initiator
  typedef struct packed {
    logic                                write;
    logic [bus_cfg_pkg::ADDR_WIDTH-1:0]  addr;
    logic [bus_cfg_pkg::DATA_WIDTH-1:0]  wdata;
  } req_t;

  // response seen by an initiator
  // writes return zero data
  typedef struct packed {
    logic [bus_cfg_pkg::DATA_WIDTH-1:0]  rdata;
    logic                                err;
  } rsp_t;

  // request after decode, tagged with destination and source
  typedef struct packed {
    req_t                   req;
    bus_cfg_pkg::tgt_idx_t  tgt;
    bus_cfg_pkg::ini_idx_t  ini;
  } routed_req_t;

  // target response, ini is the source index echoed from the request
  typedef struct packed {
    rsp_t                   rsp;
    bus_cfg_pkg::ini_idx_t  ini;
  } tgt_rsp_t;

  // answer for an unmapped cluster address
  localparam rsp_t DECODE_ERR_RSP = '{
    rdata: '0,
    err:   1'b1
  };

endpackage

`default_nettype wire

//--- source/cluster_addr_map.sv
// cluster address map
`default_nettype none

module cluster_addr_map #(
  parameter int unsigned TCDM_SIZE = 32'h0001_0000
) (
  input  logic [5:0]               cluster_id_i,
  output bus_cfg_pkg::addr_rules_t rules_o
);

  localparam int unsigned AW = bus_cfg_pkg::ADDR_WIDTH;

  typedef logic [AW-1:0] addr_t;

  addr_t cluster_id_ext;
  addr_t cluster_base;
  addr_t periph_base;
  addr_t cluster_end;

  // widen the id before shifting so the upper bits are not lost
  assign cluster_id_ext = addr_t'(cluster_id_i);

  // each cluster owns a 4 MiB window starting at its base
  assign cluster_base = bus_cfg_pkg::CLUSTER_BASE
                      + (cluster_id_ext << bus_cfg_pkg::CLUSTER_SHIFT);
  assign periph_base  = cluster_base + bus_cfg_pkg::PERIPH_OFFSET;
  assign cluster_end  = cluster_base + bus_cfg_pkg::CLUSTER_SPAN;

  always_comb begin
    // TCDM at the bottom of the window, sized by the top level
    rules_o.tcdm_start    = cluster_base;
    rules_o.tcdm_end      = cluster_base + addr_t'(TCDM_SIZE);

    // peripherals fill the upper half
    rules_o.periph_start  = periph_base;
    rules_o.periph_end    = cluster_end;

    // anything outside this range belongs to external memory
    rules_o.cluster_start = cluster_base;
    rules_o.cluster_end   = cluster_end;
  end

endmodule

`default_nettype wire

//--- source/initiator_port.sv
// cluster bus initiator port
`default_nettype none

module initiator_port #(
  parameter int unsigned PORT_IDX = 0
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  bus_cfg_pkg::addr_rules_t rules_i,

  // initiator side
  input  logic                     req_valid_i,
  input  bus_txn_pkg::req_t        req_i,
  output logic                     req_ready_o,
  output logic                     rsp_valid_o,
  output bus_txn_pkg::rsp_t        rsp_o,
  input  logic                     rsp_ready_i,

  // towards the arbiter
  output logic                     slot_valid_o,
  output bus_txn_pkg::routed_req_t slot_req_o,
  input  logic                     slot_pop_i,
  input  logic                     route_rsp_valid_i,
  input  bus_txn_pkg::rsp_t        route_rsp_i,
  output logic                     route_rsp_ready_o
);

  logic                     busy_q;
  logic                     slot_valid_q;
  logic                     err_pending_q;
  bus_txn_pkg::routed_req_t slot_req_q;

  logic                     accept;
  logic                     rsp_done;
  logic                     in_tcdm;
  logic                     in_periph;
  logic                     in_cluster;
  logic                     dec_err;
  bus_cfg_pkg::tgt_idx_t    dec_tgt;

  // one transaction in flight, so the port closes until its response is taken
  assign req_ready_o = ~busy_q;
  assign accept      = req_valid_i & req_ready_o;
  assign rsp_done    = rsp_valid_o & rsp_ready_i;

  // address decode against the cluster map
  always_comb begin
    in_tcdm    = (req_i.addr >= rules_i.tcdm_start) && (req_i.addr < rules_i.tcdm_end);
    in_periph  = (req_i.addr >= rules_i.periph_start) && (req_i.addr < rules_i.periph_end);
    in_cluster = (req_i.addr >= rules_i.cluster_start) && (req_i.addr < rules_i.cluster_end);

    dec_err = 1'b0;
    dec_tgt = bus_cfg_pkg::TGT_EXT;
    if (in_tcdm) begin
      dec_tgt = bus_cfg_pkg::TGT_TCDM;
    end else if (in_periph) begin
      dec_tgt = bus_cfg_pkg::TGT_PERIPH;
    end else if (in_cluster) begin
      // hole between TCDM and peripherals
      dec_err = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q        <= 1'b0;
      slot_valid_q  <= 1'b0;
      err_pending_q <= 1'b0;
    end else if (accept) begin
      busy_q        <= 1'b1;
      slot_valid_q  <= ~dec_err;
      err_pending_q <= dec_err;
    end else begin
      if (slot_pop_i) begin
        slot_valid_q <= 1'b0;
      end
      if (rsp_done) begin
        busy_q        <= 1'b0;
        err_pending_q <= 1'b0;
      end
    end
  end

  // slot payload, only meaningful while the slot is valid
  always_ff @(posedge clk_i) begin
    if (accept) begin
      slot_req_q.req <= req_i;
      slot_req_q.tgt <= dec_tgt;
      slot_req_q.ini <= bus_cfg_pkg::ini_idx_t'(PORT_IDX);
    end
  end

  assign slot_valid_o = slot_valid_q;
  assign slot_req_o   = slot_req_q;

  // local error response takes the port, routed responses otherwise
  assign rsp_valid_o       = err_pending_q | route_rsp_valid_i;
  assign rsp_o             = err_pending_q ? bus_txn_pkg::DECODE_ERR_RSP : route_rsp_i;
  assign route_rsp_ready_o = rsp_ready_i & ~err_pending_q;

endmodule

`default_nettype wire

//--- source/target_arbiter.sv
// round-robin target arbiter and response router
`default_nettype none

module target_arbiter #(
  parameter int unsigned NB_INITIATORS = 4,
  parameter int unsigned NB_TARGETS    = 3
) (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,

  // initiator slots
  input  logic                     [NB_INITIATORS-1:0] slot_valid_i,
  input  bus_txn_pkg::routed_req_t [NB_INITIATORS-1:0] slot_req_i,
  output logic                     [NB_INITIATORS-1:0] slot_pop_o,
  output logic                     [NB_INITIATORS-1:0] route_rsp_valid_o,
  output bus_txn_pkg::rsp_t        [NB_INITIATORS-1:0] route_rsp_o,
  input  logic                     [NB_INITIATORS-1:0] route_rsp_ready_i,

  // target ports
  output logic                     [NB_TARGETS-1:0]    tgt_req_valid_o,
  output bus_txn_pkg::routed_req_t [NB_TARGETS-1:0]    tgt_req_o,
  input  logic                     [NB_TARGETS-1:0]    tgt_req_ready_i,
  input  logic                     [NB_TARGETS-1:0]    tgt_rsp_valid_i,
  input  bus_txn_pkg::tgt_rsp_t    [NB_TARGETS-1:0]    tgt_rsp_i,
  output logic                     [NB_TARGETS-1:0]    tgt_rsp_ready_o
);

  localparam int unsigned IDX_W = (NB_INITIATORS > 1) ? $clog2(NB_INITIATORS) : 1;
  localparam int unsigned SEL_W = (NB_TARGETS > 1) ? $clog2(NB_TARGETS) : 1;

  typedef logic [IDX_W-1:0] ptr_t;
  typedef logic [SEL_W-1:0] sel_t;

  ptr_t rr_ptr_q   [NB_TARGETS];
  logic lock_q     [NB_TARGETS];
  ptr_t lock_idx_q [NB_TARGETS];

  logic gnt_found  [NB_TARGETS];
  ptr_t gnt_idx    [NB_TARGETS];
  sel_t rsp_sel    [NB_INITIATORS];

  // search from the pointer for the first slot aimed at this target
  always_comb begin : proc_grant
    int unsigned cand;
    cand = 0;
    for (int unsigned t = 0; t < NB_TARGETS; t++) begin
      gnt_found[t] = 1'b0;
      gnt_idx[t]   = '0;
      for (int unsigned k = 0; k < NB_INITIATORS; k++) begin
        cand = (rr_ptr_q[t] + k) % NB_INITIATORS;
        if (!gnt_found[t] && slot_valid_i[cand] &&
            (slot_req_i[cand].tgt == bus_cfg_pkg::tgt_idx_t'(t))) begin
          gnt_found[t] = 1'b1;
          gnt_idx[t]   = ptr_t'(cand);
        end
      end
      // a stalled request keeps its grant so the payload stays stable
      if (lock_q[t]) begin
        gnt_found[t] = 1'b1;
        gnt_idx[t]   = lock_idx_q[t];
      end
      tgt_req_valid_o[t] = gnt_found[t];
      tgt_req_o[t]       = slot_req_i[gnt_idx[t]];
    end
  end

  // release the winning slot once its target takes it
  always_comb begin : proc_pop
    slot_pop_o = '0;
    for (int unsigned t = 0; t < NB_TARGETS; t++) begin
      if (tgt_req_valid_o[t] && tgt_req_ready_i[t]) begin
        slot_pop_o[gnt_idx[t]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int unsigned t = 0; t < NB_TARGETS; t++) begin
      if (!rst_n_i) begin
        rr_ptr_q[t]   <= '0;
        lock_q[t]     <= 1'b0;
        lock_idx_q[t] <= '0;
      end else if (tgt_req_valid_o[t] && tgt_req_ready_i[t]) begin
        rr_ptr_q[t] <= ptr_t'((gnt_idx[t] + 1) % NB_INITIATORS);
        lock_q[t]   <= 1'b0;
      end else if (tgt_req_valid_o[t]) begin
        lock_q[t]     <= 1'b1;
        lock_idx_q[t] <= gnt_idx[t];
      end
    end
  end

  // route responses by the echoed index
  // walking down leaves the lowest target index as the winner
  always_comb begin : proc_rsp_route
    for (int unsigned i = 0; i < NB_INITIATORS; i++) begin
      route_rsp_valid_o[i] = 1'b0;
      route_rsp_o[i]       = '0;
      rsp_sel[i]           = '0;
      for (int t = NB_TARGETS - 1; t >= 0; t--) begin
        if (tgt_rsp_valid_i[t] && (tgt_rsp_i[t].ini == bus_cfg_pkg::ini_idx_t'(i))) begin
          route_rsp_valid_o[i] = 1'b1;
          route_rsp_o[i]       = tgt_rsp_i[t].rsp;
          rsp_sel[i]           = sel_t'(t);
        end
      end
    end

    // only the selected target sees the initiator's ready
    tgt_rsp_ready_o = '0;
    for (int unsigned i = 0; i < NB_INITIATORS; i++) begin
      if (route_rsp_valid_o[i] && route_rsp_ready_i[i]) begin
        tgt_rsp_ready_o[rsp_sel[i]] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/cluster_bus.sv
// cluster bus top level
`default_nettype none

module cluster_bus #(
  parameter int unsigned TCDM_SIZE = 32'h0001_0000
) (
  input  logic                                                    clk_i,
  input  logic                                                    rst_n_i,
  input  logic [5:0]                                              cluster_id_i,

  // initiator ports: external, DMA, core data, core instruction
  input  logic                     [bus_cfg_pkg::NB_INITIATORS-1:0] ini_req_valid_i,
  input  bus_txn_pkg::req_t        [bus_cfg_pkg::NB_INITIATORS-1:0] ini_req_i,
  output logic                     [bus_cfg_pkg::NB_INITIATORS-1:0] ini_req_ready_o,
  output logic                     [bus_cfg_pkg::NB_INITIATORS-1:0] ini_rsp_valid_o,
  output bus_txn_pkg::rsp_t        [bus_cfg_pkg::NB_INITIATORS-1:0] ini_rsp_o,
  input  logic                     [bus_cfg_pkg::NB_INITIATORS-1:0] ini_rsp_ready_i,

  // target ports: TCDM, peripherals, external memory
  output logic                     [bus_cfg_pkg::NB_TARGETS-1:0]    tgt_req_valid_o,
  output bus_txn_pkg::routed_req_t [bus_cfg_pkg::NB_TARGETS-1:0]    tgt_req_o,
  input  logic                     [bus_cfg_pkg::NB_TARGETS-1:0]    tgt_req_ready_i,
  input  logic                     [bus_cfg_pkg::NB_TARGETS-1:0]    tgt_rsp_valid_i,
  input  bus_txn_pkg::tgt_rsp_t    [bus_cfg_pkg::NB_TARGETS-1:0]    tgt_rsp_i,
  output logic                     [bus_cfg_pkg::NB_TARGETS-1:0]    tgt_rsp_ready_o
);

  bus_cfg_pkg::addr_rules_t                                  rules;
  logic                     [bus_cfg_pkg::NB_INITIATORS-1:0] slot_valid;
  bus_txn_pkg::routed_req_t [bus_cfg_pkg::NB_INITIATORS-1:0] slot_req;
  logic                     [bus_cfg_pkg::NB_INITIATORS-1:0] slot_pop;
  logic                     [bus_cfg_pkg::NB_INITIATORS-1:0] route_rsp_valid;
  bus_txn_pkg::rsp_t        [bus_cfg_pkg::NB_INITIATORS-1:0] route_rsp;
  logic                     [bus_cfg_pkg::NB_INITIATORS-1:0] route_rsp_ready;

  cluster_addr_map #(
    .TCDM_SIZE ( TCDM_SIZE )
  ) i_addr_map (
    .cluster_id_i ( cluster_id_i ),
    .rules_o      ( rules        )
  );

  for (genvar i = 0; i < bus_cfg_pkg::NB_INITIATORS; i++) begin : gen_ini_port
    initiator_port #(
      .PORT_IDX ( i )
    ) i_initiator_port (
      .clk_i             ( clk_i              ),
      .rst_n_i           ( rst_n_i            ),
      .rules_i           ( rules              ),
      .req_valid_i       ( ini_req_valid_i[i] ),
      .req_i             ( ini_req_i[i]       ),
      .req_ready_o       ( ini_req_ready_o[i] ),
      .rsp_valid_o       ( ini_rsp_valid_o[i] ),
      .rsp_o             ( ini_rsp_o[i]       ),
      .rsp_ready_i       ( ini_rsp_ready_i[i] ),
      .slot_valid_o      ( slot_valid[i]      ),
      .slot_req_o        ( slot_req[i]        ),
      .slot_pop_i        ( slot_pop[i]        ),
      .route_rsp_valid_i ( route_rsp_valid[i] ),
      .route_rsp_i       ( route_rsp[i]       ),
      .route_rsp_ready_o ( route_rsp_ready[i] )
    );
  end

  target_arbiter #(
    .NB_INITIATORS ( bus_cfg_pkg::NB_INITIATORS ),
    .NB_TARGETS    ( bus_cfg_pkg::NB_TARGETS    )
  ) i_target_arbiter (
    .clk_i             ( clk_i           ),
    .rst_n_i           ( rst_n_i         ),
    .slot_valid_i      ( slot_valid      ),
    .slot_req_i        ( slot_req        ),
    .slot_pop_o        ( slot_pop        ),
    .route_rsp_valid_o ( route_rsp_valid ),
    .route_rsp_o       ( route_rsp       ),
    .route_rsp_ready_i ( route_rsp_ready ),
    .tgt_req_valid_o   ( tgt_req_valid_o ),
    .tgt_req_o         ( tgt_req_o       ),
    .tgt_req_ready_i   ( tgt_req_ready_i ),
    .tgt_rsp_valid_i   ( tgt_rsp_valid_i ),
    .tgt_rsp_i         ( tgt_rsp_i       ),
    .tgt_rsp_ready_o   ( tgt_rsp_ready_o )
  );

endmodule

`default_nettype wire

//--- bench/tb_target_model.sv
// behavioral target memory
`default_nettype none

module tb_target_model (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // bit 0 allows acceptance, bits 2:1 give the extra response delay
  input  logic [2:0]               rnd_i,
  input  logic                     req_valid_i,
  input  bus_txn_pkg::routed_req_t req_i,
  output logic                     req_ready_o,
  output logic                     rsp_valid_o,
  output bus_txn_pkg::tgt_rsp_t    rsp_o,
  input  logic                     rsp_ready_i
);

  logic [31:0] mem [256];
  logic        busy;
  logic [1:0]  delay;

  initial begin
    busy        = 1'b0;
    delay       = '0;
    rsp_valid_o = 1'b0;
    rsp_o       = '0;
    for (int w = 0; w < 256; w++) begin
      mem[w] = '0;
    end
  end

  // one transaction at a time
  assign req_ready_o = rnd_i[0] & ~busy;

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy        <= 1'b0;
      rsp_valid_o <= 1'b0;
    end else if (req_valid_i && req_ready_o) begin
      busy            <= 1'b1;
      delay           <= rnd_i[2:1];
      rsp_o.ini       <= req_i.ini;
      rsp_o.rsp.err   <= 1'b0;
      // writes answer with zero data
      rsp_o.rsp.rdata <= req_i.req.write ? 32'h0 : mem[req_i.req.addr[9:2]];
      if (req_i.req.write) begin
        mem[req_i.req.addr[9:2]] <= req_i.req.wdata;
      end
    end else if (busy && !rsp_valid_o) begin
      if (delay == 2'd0) begin
        rsp_valid_o <= 1'b1;
      end else begin
        delay <= delay - 2'd1;
      end
    end else if (rsp_valid_o && rsp_ready_i) begin
      busy        <= 1'b0;
      rsp_valid_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_cluster_bus.sv
// cluster bus testbench
`default_nettype none

module tb_cluster_bus;

  localparam int unsigned TCDM_SIZE = 32'h0001_0000;
  // index 3 marks a decode error
  localparam bus_cfg_pkg::tgt_idx_t DEC_ERR = 2'd3;

  logic                           clk_i = 1'b0;
  logic                           rst_n_i;
  logic [5:0]                     cluster_id_i;
  logic [3:0]                     ini_req_valid_i;
  bus_txn_pkg::req_t [3:0]        ini_req_i;
  logic [3:0]                     ini_req_ready_o;
  logic [3:0]                     ini_rsp_valid_o;
  bus_txn_pkg::rsp_t [3:0]        ini_rsp_o;
  logic [3:0]                     ini_rsp_ready_i;
  logic [2:0]                     tgt_req_valid_o;
  bus_txn_pkg::routed_req_t [2:0] tgt_req_o;
  logic [2:0]                     tgt_req_ready_i;
  logic [2:0]                     tgt_rsp_valid_i;
  bus_txn_pkg::tgt_rsp_t [2:0]    tgt_rsp_i;
  logic [2:0]                     tgt_rsp_ready_o;

  logic [31:0]                    lfsr = 32'h84d9_9a4f;
  logic                           bp_mode;
  logic [2:0]                     model_rnd [3];

  // scoreboard state per initiator
  bus_txn_pkg::req_t              acc_req [4];
  bus_txn_pkg::rsp_t              exp_rsp [4];
  logic                           accepted [4];
  logic                           granted [4];
  int                             passed [4];
  logic [31:0]                    shadow [3][256];

  always #2 clk_i = ~clk_i;

  cluster_bus #(
    .TCDM_SIZE ( TCDM_SIZE )
  ) i_cluster_bus (.*);

  for (genvar t = 0; t < 3; t++) begin : gen_target
    tb_target_model i_target_model (
      .clk_i       ( clk_i              ),
      .rst_n_i     ( rst_n_i            ),
      .rnd_i       ( model_rnd[t]       ),
      .req_valid_i ( tgt_req_valid_o[t] ),
      .req_i       ( tgt_req_o[t]       ),
      .req_ready_o ( tgt_req_ready_i[t] ),
      .rsp_valid_o ( tgt_rsp_valid_i[t] ),
      .rsp_o       ( tgt_rsp_i[t]       ),
      .rsp_ready_i ( tgt_rsp_ready_o[t] )
    );
  end

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [3:0] take_bits(input int n);
    logic [3:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v[k] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  function automatic logic [31:0] window_base(input logic [5:0] cid);
    return bus_cfg_pkg::CLUSTER_BASE + ({26'b0, cid} << bus_cfg_pkg::CLUSTER_SHIFT);
  endfunction

  function automatic bus_cfg_pkg::tgt_idx_t expected_target(input logic [31:0] addr,
                                                             input logic [5:0]  cid);
    logic [31:0] off;
    off = addr - window_base(cid);
    // below the base the offset wraps beyond the span
    if (off >= bus_cfg_pkg::CLUSTER_SPAN) return 2'd2;
    if (off < TCDM_SIZE) return 2'd0;
    if (off >= bus_cfg_pkg::PERIPH_OFFSET) return 2'd1;
    return DEC_ERR;
  endfunction

  task automatic stop_failed();
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at time %0t: %s", $time, msg);
    stop_failed();
  endtask

  task automatic check_rsp(input string name, input bus_txn_pkg::rsp_t exp,
                           input bus_txn_pkg::rsp_t act);
    if (act !== exp) begin
      $display("FAILED time=%0t %s expected %h actual %h", $time, name, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_target(input string name, input bus_cfg_pkg::tgt_idx_t exp,
                              input bus_cfg_pkg::tgt_idx_t act);
    if (act !== exp) begin
      $display("FAILED time=%0t %s expected %0d actual %0d", $time, name, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_req(input string name, input bus_txn_pkg::req_t exp,
                           input bus_txn_pkg::req_t act);
    if (act !== exp) begin
      $display("FAILED time=%0t %s expected %h actual %h", $time, name, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_bits(input string name, input logic [3:0] exp, input logic [3:0] act);
    if (act !== exp) begin
      $display("FAILED time=%0t %s expected %b actual %b", $time, name, exp, act);
      stop_failed();
    end
  endtask

  // one transaction on one initiator that returns after its response handshake
  task automatic run_txn(input int i, input logic wr, input logic [31:0] addr,
                         input logic [31:0] data);
    bus_txn_pkg::req_t req;
    int                cnt;
    req.write = wr;
    req.addr  = addr;
    req.wdata = data;
    @(posedge clk_i);
    ini_req_valid_i[i] <= 1'b1;
    ini_req_i[i]       <= req;
    cnt = 0;
    @(posedge clk_i);
    while (!ini_req_ready_o[i] && cnt < 200) begin
      @(posedge clk_i);
      cnt++;
    end
    if (!ini_req_ready_o[i]) report_error($sformatf("initiator %0d request never accepted", i));
    ini_req_valid_i[i] <= 1'b0;
    cnt = 0;
    @(posedge clk_i);
    while (!(ini_rsp_valid_o[i] && ini_rsp_ready_i[i]) && cnt < 200) begin
      @(posedge clk_i);
      cnt++;
    end
    if (!(ini_rsp_valid_o[i] && ini_rsp_ready_i[i])) begin
      report_error($sformatf("initiator %0d response never arrived", i));
    end
  endtask

  // TCDM only or spread over all windows and the hole
  task automatic run_stream(input int i, input int n, input bit mixed);
    logic [31:0] base;
    logic [31:0] addr;
    base = window_base(cluster_id_i);
    for (int k = 0; k < n; k++) begin
      case (mixed ? (i + k) % 4 : 0)
        1:       addr = base + bus_cfg_pkg::PERIPH_OFFSET + 32'h80 + (k % 4) * 4;
        2:       addr = base + bus_cfg_pkg::CLUSTER_SPAN + i * 16;
        3:       addr = base + TCDM_SIZE + 32'h40;
        default: addr = base + 32'h400 + ((k / 2) % 2) * 4;
      endcase
      run_txn(i, ~k[0], addr, 32'h5a00_0000 | (i << 8) | k);
    end
  endtask

  // target ready and delay
  // initiator response ready only under back-pressure
  always @(posedge clk_i) begin : proc_env
    logic [3:0] r;
    for (int t = 0; t < 3; t++) begin
      r = take_bits(3);
      model_rnd[t] <= {r[2:1], r[0] | ~bp_mode};
    end
    r = take_bits(4);
    ini_rsp_ready_i <= bp_mode ? r : 4'hf;
  end

  // compares every handshake against the expected results
  always @(posedge clk_i) begin : proc_compare
    bus_cfg_pkg::ini_idx_t src;
    logic [7:0]            w;
    logic [2:0]            rsp_rdy;
    if (rst_n_i) begin
      for (int i = 0; i < 4; i++) begin
        if (ini_req_valid_i[i] && ini_req_ready_o[i]) begin
          acc_req[i]  = ini_req_i[i];
          accepted[i] = 1'b1;
          granted[i]  = 1'b0;
          passed[i]   = 0;
          // routed answers are only known once a target takes the request
          exp_rsp[i]  = 'x;
          if (expected_target(ini_req_i[i].addr, cluster_id_i) == DEC_ERR) begin
            exp_rsp[i] = '{rdata: 32'h0, err: 1'b1};
          end
        end else if (accepted[i] && ini_req_ready_o[i]) begin
          report_error($sformatf("initiator %0d ready again before its response", i));
        end
        if (ini_rsp_valid_o[i] && ini_rsp_ready_i[i]) begin
          if (!accepted[i]) report_error($sformatf("initiator %0d got an extra response", i));
          check_rsp($sformatf("ini_rsp_o[%0d]", i), exp_rsp[i], ini_rsp_o[i]);
          accepted[i] = 1'b0;
        end
      end
      for (int t = 0; t < 3; t++) begin
        if (tgt_req_valid_o[t]) begin
          src = tgt_req_o[t].ini;
          if (!accepted[src] || granted[src]) begin
            report_error($sformatf("target %0d shows a request with no open transaction", t));
          end
          check_target($sformatf("tgt_req_valid_o port for initiator %0d", src),
                       expected_target(acc_req[src].addr, cluster_id_i),
                       bus_cfg_pkg::tgt_idx_t'(t));
          check_target($sformatf("tgt_req_o[%0d].tgt", t),
                       expected_target(acc_req[src].addr, cluster_id_i),
                       tgt_req_o[t].tgt);
          check_req($sformatf("tgt_req_o[%0d].req", t), acc_req[src], tgt_req_o[t].req);
          if (tgt_req_ready_i[t]) begin
            w            = acc_req[src].addr[9:2];
            granted[src] = 1'b1;
            exp_rsp[src] = '{rdata: acc_req[src].write ? 32'h0 : shadow[t][w], err: 1'b0};
            if (acc_req[src].write) shadow[t][w] = acc_req[src].wdata;
            // everyone still waiting for this target was passed over once more
            for (int j = 0; j < 4; j++) begin
              if (accepted[j] && !granted[j] &&
                  expected_target(acc_req[j].addr, cluster_id_i) == t) begin
                passed[j]++;
                if (passed[j] > 4) report_error($sformatf("initiator %0d starved", j));
              end
            end
          end
        end
      end
      // a target response waits on the ready of the initiator it names
      rsp_rdy = '0;
      for (int t = 0; t < 3; t++) begin
        if (tgt_rsp_valid_i[t]) begin
          rsp_rdy[t] = ini_rsp_ready_i[tgt_rsp_i[t].ini];
        end
      end
      check_bits("tgt_rsp_ready_o", {1'b0, rsp_rdy}, {1'b0, tgt_rsp_ready_o});
    end
  end

  initial begin : proc_stimulus
    logic [31:0] base;
    rst_n_i         = 1'b0;
    cluster_id_i    = '0;
    ini_req_valid_i = '0;
    ini_req_i       = '0;
    ini_rsp_ready_i = '1;
    bp_mode         = 1'b0;
    for (int t = 0; t < 3; t++) begin
      model_rnd[t] = '0;
      for (int k = 0; k < 256; k++) begin
        shadow[t][k] = '0;
      end
    end
    for (int i = 0; i < 4; i++) begin
      accepted[i] = 1'b0;
      granted[i]  = 1'b0;
      passed[i]   = 0;
      acc_req[i]  = '0;
      exp_rsp[i]  = '0;
    end
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // idle state straight out of reset
    @(posedge clk_i);
    check_bits("ini_req_ready_o", 4'hf, ini_req_ready_o);
    check_bits("ini_rsp_valid_o", 4'h0, ini_rsp_valid_o);
    check_bits("tgt_req_valid_o", 4'h0, {1'b0, tgt_req_valid_o});

    // every window for two clusters read back from another initiator
    for (int c = 0; c < 6; c += 5) begin
      @(posedge clk_i);
      cluster_id_i <= 6'(c);
      base = window_base(6'(c));
      run_txn(0, 1'b1, base + 32'h100, 32'h1111_0000 + c);
      run_txn(1, 1'b1, base + bus_cfg_pkg::PERIPH_OFFSET + 32'h40, 32'h2222_0000 + c);
      run_txn(2, 1'b1, base - 32'h4, 32'h3333_0000 + c);
      run_txn(3, 1'b1, base + bus_cfg_pkg::CLUSTER_SPAN + 32'h8, 32'h4444_0000 + c);
      run_txn(3, 1'b0, base + 32'h100, '0);
      run_txn(0, 1'b0, base + bus_cfg_pkg::PERIPH_OFFSET + 32'h40, '0);
      run_txn(1, 1'b0, base - 32'h4, '0);
      run_txn(2, 1'b0, base + bus_cfg_pkg::CLUSTER_SPAN + 32'h8, '0);
      // hole between TCDM and peripherals
      run_txn(2, 1'b0, base + TCDM_SIZE + 32'h20, '0);
      run_txn(1, 1'b1, base + TCDM_SIZE + 32'h24, 32'hdead_beef);
    end

    // all initiators competing for TCDM
    fork
      run_stream(0, 8, 1'b0);
      run_stream(1, 8, 1'b0);
      run_stream(2, 8, 1'b0);
      run_stream(3, 8, 1'b0);
    join

    // random stalls on both sides
    @(posedge clk_i);
    bp_mode <= 1'b1;
    fork
      run_stream(0, 12, 1'b1);
      run_stream(1, 12, 1'b1);
      run_stream(2, 12, 1'b1);
      run_stream(3, 12, 1'b1);
    join

    @(posedge clk_i);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
source/bus_cfg_pkg.sv
source/bus_txn_pkg.sv
source/cluster_addr_map.sv
source/initiator_port.sv
source/target_arbiter.sv
source/cluster_bus.sv
bench/tb_target_model.sv
bench/tb_cluster_bus.sv
